// ==== build.f ====
rtl/bcdAddPkg.sv
rtl/binToBcd.sv
rtl/bcdAddDatapath.sv
rtl/bcdAddControl.sv
rtl/bcdAddTop.sv
verif/tbClockGen.sv
verif/bcdAddTb.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := bcdAddTb
FILELIST   := build.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/bcdAddTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcdAddTb;

    import bcdAddPkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RSP_LATENCY    = 2;
    localparam int RANDOM_CMDS    = 300;

    logic   CLK;
    logic   rstN;
    bcdCmdT cmd;
    logic   cmdValid;
    logic   cmdReady;
    bcdRspT rsp;
    logic   rspValid;
    logic   rspReady;

    // Reference model registers
    int modelA;
    int modelB;
    int modelSum;

    // Commands in issue order
    bcdCmdT cmdQueue[$];

    tbClockGen clkGen
    (
        .CLK  (CLK),
        .rstN (rstN)
    );

    bcdAddTop DUT
    (
        .CLK      (CLK),
        .rstN     (rstN),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .rsp      (rsp),
        .rspValid (rspValid),
        .rspReady (rspReady)
    );

    //////////////////////////////////////////////////////////////////////
    // Error reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            reportFailure($sformatf("FAILED at %0t: %s got %0b expected %0b",
                $time, name, got, exp));
    endtask

    task automatic compareLatency(input int got, input int exp);
        if (got != exp)
            reportFailure($sformatf("FAILED at %0t: rspValid latency got %0d expected %0d",
                $time, got, exp));
    endtask

    // One check per response field
    task automatic compareRsp(input string name, input bcdRspT got, input bcdRspT exp);
        if (got.op !== exp.op)
            reportFailure($sformatf("FAILED at %0t: %s.op got %s expected %s",
                $time, name, got.op.name(), exp.op.name()));
        if (got.digits !== exp.digits)
            reportFailure($sformatf("FAILED at %0t: %s.digits got %h expected %h",
                $time, name, got.digits, exp.digits));
        if (got.error !== exp.error)
            reportFailure($sformatf("FAILED at %0t: %s.error got %0b expected %0b",
                $time, name, got.error, exp.error));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Decimal digits by division with tens in upper nibble
    function automatic bcdPairT toBcdPair(input int value);
        bcdPairT pair;
        pair[7:4] = 4'((value / 10) % 10);
        pair[3:0] = 4'(value % 10);
        return pair;
    endfunction

    task automatic predictRsp(input bcdCmdT c, output bcdRspT exp);
        int value;
        value = int'(c.data);
        exp.op = c.op;
        exp.digits = '0;
        exp.error = 1'b0;
        case (c.op)
            opInit:
            begin
                modelA = 0;
                modelB = 0;
                modelSum = 0;
            end
            opLoadA:
            begin
                // Refused load keeps the old operand
                if (value > 99)
                    exp.error = 1'b1;
                else
                    modelA = value;
            end
            opLoadB:
            begin
                if (value > 99)
                    exp.error = 1'b1;
                else
                    modelB = value;
            end
            opShowA:  exp.digits = toBcdPair(modelA);
            opShowB:  exp.digits = toBcdPair(modelB);
            opAdd:    modelSum = modelA + modelB;
            opShowLs: exp.digits = toBcdPair(modelSum % 100);
            default:
            begin
                // Hundreds digit alone in low nibble
                exp.digits = {4'd0, 4'(modelSum / 100)};
            end
        endcase
    endtask

    // Loads weighted three to one over the other opcodes
    function automatic bcdOpT pickOp(input int pick);
        case (pick)
            0, 1, 2: return opLoadA;
            3, 4, 5: return opLoadB;
            6:       return opShowA;
            7:       return opShowB;
            8:       return opAdd;
            9:       return opShowLs;
            10:      return opShowMs;
            default: return opInit;
        endcase
    endfunction

    // Appends one command to the issue order
    task automatic queueCmd(input bcdOpT op, input binByteT data);
        bcdCmdT c;
        c.op = op;
        c.data = data;
        cmdQueue.push_back(c);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Command and response sequence
    //////////////////////////////////////////////////////////////////////

    // Entered and left on a rising edge
    task automatic runCmd(input bcdCmdT c, input logic hasNext, input bcdCmdT nextCmd);
        bcdRspT expRsp;
        bcdRspT held;
        int     waited;
        int     latency;
        int     holdCycles;
        logic   seenValid;
        predictRsp(c, expRsp);
        cmd <= c;
        cmdValid <= 1'b1;
        // Handshake flags sampled mid-cycle
        waited = 0;
        @(negedge CLK);
        while (!cmdReady)
        begin
            waited++;
            if (waited >= TIMEOUT_CYCLES)
                reportFailure("Timeout: cmdReady never rose for a waiting command");
            @(negedge CLK);
        end
        // Transfer edge
        @(posedge CLK);
        cmdValid <= 1'b0;
        // Edges from transfer to the first edge that sees rspValid
        latency = 0;
        seenValid = 1'b0;
        held = '0;
        while (!seenValid)
        begin
            @(negedge CLK);
            seenValid = rspValid;
            held = rsp;
            compareBit("cmdReady", cmdReady, 1'b0);
            @(posedge CLK);
            latency++;
            if (!seenValid && latency >= TIMEOUT_CYCLES)
                reportFailure("Timeout: no response after a command transfer");
        end
        compareLatency(latency, RSP_LATENCY);
        // Next command stays pending while the response stalls
        if (hasNext)
        begin
            cmd <= nextCmd;
            cmdValid <= 1'b1;
        end
        // Random back-pressure
        holdCycles = $urandom_range(3, 0);
        for (int i = 0; i < holdCycles; i++)
        begin
            rspReady <= 1'b0;
            @(negedge CLK);
            compareBit("rspValid", rspValid, 1'b1);
            compareBit("cmdReady", cmdReady, 1'b0);
            compareRsp("rsp held", rsp, held);
            @(posedge CLK);
        end
        rspReady <= 1'b1;
        @(negedge CLK);
        compareBit("rspValid", rspValid, 1'b1);
        compareRsp("rsp", rsp, expRsp);
        // Response transfer edge
        @(posedge CLK);
        rspReady <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        int      waited;
        bcdOpT   op;
        binByteT data;
        cmd = '0;
        cmdValid = 1'b0;
        rspReady = 1'b0;
        modelA = 0;
        modelB = 0;
        modelSum = 0;
        void'($urandom(70));

        // Reset release
        waited = 0;
        @(negedge CLK);
        while (!rstN)
        begin
            waited++;
            if (waited >= TIMEOUT_CYCLES)
                reportFailure("Timeout: reset was never released");
            @(negedge CLK);
        end
        compareBit("cmdReady", cmdReady, 1'b1);
        compareBit("rspValid", rspValid, 1'b0);
        @(posedge CLK);

        // Directed load, range and add cases
        queueCmd(opInit, 8'd0);
        queueCmd(opLoadA, 8'd42);
        queueCmd(opShowA, 8'd0);
        queueCmd(opLoadA, 8'd150);
        queueCmd(opShowA, 8'd0);
        queueCmd(opLoadB, 8'd99);
        queueCmd(opShowB, 8'd0);
        queueCmd(opAdd, 8'd0);
        queueCmd(opShowLs, 8'd0);
        queueCmd(opShowMs, 8'd0);
        // Clear then every show reads zero
        queueCmd(opInit, 8'd0);
        queueCmd(opShowA, 8'd0);
        queueCmd(opShowB, 8'd0);
        queueCmd(opShowLs, 8'd0);
        queueCmd(opShowMs, 8'd0);

        // Random commands with data up to 255
        for (int n = 0; n < RANDOM_CMDS; n++)
        begin
            op = pickOp($urandom_range(11, 0));
            data = 8'($urandom_range(255, 0));
            queueCmd(op, data);
        end

        // Each command but the last hands its successor over early
        for (int n = 0; n < cmdQueue.size(); n++)
        begin
            if (n + 1 < cmdQueue.size())
                runCmd(cmdQueue[n], 1'b1, cmdQueue[n + 1]);
            else
                runCmd(cmdQueue[n], 1'b0, '0);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
    output logic CLK,
    output logic rstN
);

    // 20 ns period
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial
    begin
        CLK = 1'b0;
        forever
            #HALF_PERIOD CLK = ~CLK;
    end

    // Reset low for ten rising edges, released on an edge
    initial
    begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/bcdAddTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcdAddTop
(
    input  logic              CLK,
    input  logic              rstN,
    input  bcdAddPkg::bcdCmdT cmd,
    input  logic              cmdValid,
    output logic              cmdReady,
    output bcdAddPkg::bcdRspT rsp,
    output logic              rspValid,
    input  logic              rspReady
);

    import bcdAddPkg::*;

    // Controller to datapath
    dpCtrlT   dpCtrl;
    binByteT  cmdData;
    // Datapath back to controller
    bcdPairT  shown;
    bcdDigitT hundredsDigit;
    logic     rangeError;

    bcdAddControl ctrlInst
    (
        .CLK           (CLK),
        .rstN          (rstN),
        .cmd           (cmd),
        .cmdValid      (cmdValid),
        .cmdReady      (cmdReady),
        .rsp           (rsp),
        .rspValid      (rspValid),
        .rspReady      (rspReady),
        .dpCtrl        (dpCtrl),
        .cmdData       (cmdData),
        .shown         (shown),
        .hundredsDigit (hundredsDigit),
        .rangeError    (rangeError)
    );

    bcdAddDatapath dpInst
    (
        .CLK           (CLK),
        .rstN          (rstN),
        .dpCtrl        (dpCtrl),
        .cmdData       (cmdData),
        .shown         (shown),
        .hundredsDigit (hundredsDigit),
        .rangeError    (rangeError)
    );

endmodule

`default_nettype wire

// ==== rtl/bcdAddControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcdAddControl
(
    input  logic                CLK,
    input  logic                rstN,
    input  bcdAddPkg::bcdCmdT   cmd,
    input  logic                cmdValid,
    output logic                cmdReady,
    output bcdAddPkg::bcdRspT   rsp,
    output logic                rspValid,
    input  logic                rspReady,
    output bcdAddPkg::dpCtrlT   dpCtrl,
    output bcdAddPkg::binByteT  cmdData,
    input  bcdAddPkg::bcdPairT  shown,
    input  bcdAddPkg::bcdDigitT hundredsDigit,
    input  logic                rangeError
);

    import bcdAddPkg::*;

    typedef enum logic [1:0] {stIdle, stExec, stRespond} ctrlStateT;

    ctrlStateT state;
    bcdCmdT    cmdReg;
    bcdRspT    rspReg;
    bcdPairT   rspDigits;
    logic      isLoad;

    // Handshake flags straight from state
    assign cmdReady = (state == stIdle);
    assign rspValid = (state == stRespond);
    assign rsp      = rspReg;
    assign cmdData  = cmdReg.data;
    assign isLoad   = (cmdReg.op == opLoadA) || (cmdReg.op == opLoadB);

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            state  <= stIdle;
            cmdReg <= '0;
            rspReg <= '0;
        end
        else
        begin
            case (state)
                stIdle:
                begin
                    // Latch command on transfer
                    if (cmdValid)
                    begin
                        cmdReg <= cmd;
                        state  <= stExec;
                    end
                end
                stExec:
                begin
                    // Range flag sampled while cmdData still applied
                    rspReg.op     <= cmdReg.op;
                    rspReg.digits <= rspDigits;
                    rspReg.error  <= isLoad && rangeError;
                    state         <= stRespond;
                end
                default:
                begin
                    // Back-pressure holds us here
                    if (rspReady)
                        state <= stIdle;
                end
            endcase
        end
    end

    // Strobes only in Exec, one cycle wide
    always_comb
    begin
        dpCtrl = '0;
        dpCtrl.showSel = SHOW_A;
        if (state == stExec)
        begin
            case (cmdReg.op)
                opInit:             dpCtrl.clear = 1'b1;
                opLoadA:            dpCtrl.loadA = 1'b1;
                opLoadB:            dpCtrl.loadB = 1'b1;
                opAdd:              dpCtrl.add = 1'b1;
                opShowB:            dpCtrl.showSel = SHOW_B;
                opShowLs, opShowMs: dpCtrl.showSel = SHOW_SUM;
                default:            dpCtrl.showSel = SHOW_A;
            endcase
        end
    end

    // Digits for the response packet
    always_comb
    begin
        case (cmdReg.op)
            opShowA, opShowB, opShowLs: rspDigits = shown;
            opShowMs:                   rspDigits = {4'd0, hundredsDigit};
            default:                    rspDigits = '0;
        endcase
    end

    // Response held while the consumer stalls
    assert property (@(posedge CLK) disable iff (!rstN)
        (rspValid && !rspReady) |=> $stable(rsp))
        else $error("bcdAddControl response changed under back-pressure");

endmodule

`default_nettype wire

// ==== rtl/bcdAddDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcdAddDatapath
(
    input  logic                CLK,
    input  logic                rstN,
    input  bcdAddPkg::dpCtrlT   dpCtrl,
    input  bcdAddPkg::binByteT  cmdData,
    output bcdAddPkg::bcdPairT  shown,
    output bcdAddPkg::bcdDigitT hundredsDigit,
    output logic                rangeError
);

    import bcdAddPkg::*;

    // Operand and result registers
    binByteT opA;
    binByteT opB;
    binByteT sum;

    // Converter side
    binByteT  convIn;
    bcdDigitT tensDigit;
    bcdDigitT onesDigit;

    // Loads above 99 are refused
    assign rangeError = (cmdData > OPERAND_MAX);

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    // Strobes arrive in Exec, registers update on the edge ending it
    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            opA <= '0;
            opB <= '0;
            sum <= '0;
        end
        else if (dpCtrl.clear)
        begin
            opA <= '0;
            opB <= '0;
            sum <= '0;
        end
        else
        begin
            // Out of range load keeps old value
            if (dpCtrl.loadA && !rangeError)
                opA <= cmdData;
            if (dpCtrl.loadB && !rangeError)
                opB <= cmdData;
            // Max 99 + 99 = 198, fits in 8 bits
            if (dpCtrl.add)
                sum <= opA + opB;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Shown value
    //////////////////////////////////////////////////////////////////////

    // Single converter behind a select
    always_comb
    begin
        case (dpCtrl.showSel)
            SHOW_A:  convIn = opA;
            SHOW_B:  convIn = opB;
            default: convIn = sum;
        endcase
    end

    binToBcd conv
    (
        .bin      (convIn),
        .hundreds (hundredsDigit),
        .tens     (tensDigit),
        .ones     (onesDigit)
    );

    assign shown = {tensDigit, onesDigit};

    // Controller issues one operation per command
    assert property (@(posedge CLK) disable iff (!rstN)
        $onehot0({dpCtrl.clear, dpCtrl.loadA, dpCtrl.loadB, dpCtrl.add}))
        else $error("bcdAddDatapath more than one strobe active");

endmodule

`default_nettype wire

// ==== rtl/binToBcd.sv ====
`timescale 1ns/1ps
`default_nettype none

module binToBcd
(
    input  bcdAddPkg::binByteT  bin,
    output bcdAddPkg::bcdDigitT hundreds,
    output bcdAddPkg::bcdDigitT tens,
    output bcdAddPkg::bcdDigitT ones
);

    //////////////////////////////////////////////////////////////////////
    // Shift and add three
    //////////////////////////////////////////////////////////////////////

    // Work register layout
    // [19:16] hundreds, [15:12] tens, [11:8] ones, [7:0] binary
    always_comb
    begin : convert
        logic [19:0] work;
        work = '0;
        work[7:0] = bin;
        // One pass per input bit
        for (int i = 0; i < 8; i++)
        begin
            // Pre-correct any digit that would pass 9 after doubling
            if (work[11:8] >= 4'd5)
                work[11:8] = work[11:8] + 4'd3;
            if (work[15:12] >= 4'd5)
                work[15:12] = work[15:12] + 4'd3;
            if (work[19:16] >= 4'd5)
                work[19:16] = work[19:16] + 4'd3;
            work = work << 1;
        end
        hundreds = work[19:16];
        tens     = work[15:12];
        ones     = work[11:8];
    end

    // Every digit decimal after the last pass
    always_comb
    begin
        assert #0 ((hundreds <= 4'd9) && (tens <= 4'd9) && (ones <= 4'd9))
            else $error("binToBcd digit above 9 for input %0d", bin);
    end

endmodule

`default_nettype wire

// ==== rtl/bcdAddPkg.sv ====
`default_nettype none

package bcdAddPkg;

    //////////////////////////////////////////////////////////////////////
    // Width types
    //////////////////////////////////////////////////////////////////////

    // Binary operand or sum
    typedef logic [7:0] binByteT;
    // Single decimal digit
    typedef logic [3:0] bcdDigitT;
    // Tens in upper nibble, ones in lower
    typedef logic [7:0] bcdPairT;

    // Command opcodes
    typedef enum logic [2:0] {
        opInit,
        opLoadA,
        opLoadB,
        opShowA,
        opShowB,
        opAdd,
        opShowLs,
        opShowMs
    } bcdOpT;

    //////////////////////////////////////////////////////////////////////
    // Port bundles
    //////////////////////////////////////////////////////////////////////

    // Command packet
    typedef struct packed {
        bcdOpT   op;
        binByteT data;
    } bcdCmdT;

    // Response packet, one per command
    typedef struct packed {
        bcdOpT   op;
        bcdPairT digits;
        logic    error;
    } bcdRspT;

    // Controller to datapath strobes
    typedef struct packed {
        logic       clear;
        logic       loadA;
        logic       loadB;
        logic       add;
        logic [1:0] showSel;
    } dpCtrlT;

    // Largest loadable operand
    localparam binByteT OPERAND_MAX = 8'd99;

    // Converter source select codes
    localparam logic [1:0] SHOW_A   = 2'd0;
    localparam logic [1:0] SHOW_B   = 2'd1;
    localparam logic [1:0] SHOW_SUM = 2'd2;

endpackage

`default_nettype wire
